/* common/div_pkg.sv */
`default_nettype none

package div_pkg;

  // ============================================================
  // Widths
  // ============================================================
  localparam int DIVIDEND_W = 16;
  localparam int DIVISOR_W  = 8;
  localparam int ERR_SUM_W  = 24;
  localparam int COUNT_W    = 16;

  localparam int APPROX_ROWS_DEFAULT = 6;  // Low quotient rows with the inexact cell.
  localparam int BATCH_LEN_DEFAULT   = 64; // Samples per statistics batch.

  // ============================================================
  // Types
  // ============================================================
  typedef logic [DIVIDEND_W-1:0] dividend_t;
  typedef logic [DIVISOR_W-1:0]  divisor_t;
  typedef divisor_t              quot_t;     // Quotient and remainder share the divisor width.
  typedef logic [ERR_SUM_W-1:0]  err_sum_t;
  typedef logic [DIVISOR_W-1:0]  err_max_t;
  typedef logic [COUNT_W-1:0]    count_t;

  typedef enum logic [1:0] {
    IDLE,
    COLLECT,
    REPORT
  } batch_state_e;

endpackage

`default_nettype wire

/* common/div_sample_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface div_sample_if import div_pkg::*; ();

  logic  strobe; // One-cycle result valid.
  quot_t q_apx;
  quot_t r_apx;
  quot_t q_ref;  // Exact array results.
  quot_t r_ref;

  modport src (
    output strobe,
    output q_apx,
    output r_apx,
    output q_ref,
    output r_ref
  );

  modport dst (
    input strobe,
    input q_apx,
    input r_apx,
    input q_ref,
    input r_ref
  );

endinterface

`default_nettype wire

/* div_array/div_cell.sv */
`timescale 1ns/1ps
`default_nettype none

module div_cell #(
  parameter bit APPROX = 1'b0
) (
  input  logic x,
  input  logic y,
  input  logic bin,
  input  logic qs,
  output logic r_sub,
  output logic bout
);

  logic diff;

  if (APPROX) begin : g_approx
    assign bout = y | bin;          // Borrow taken whenever y or borrow-in.
    assign diff = ~(~x & y & ~bin); // Only 0-1-0 gives a zero difference.
  end else begin : g_exact
    assign diff = x ^ y ^ bin;
    assign bout = (~x & y) | (~(x ^ y) & bin);
  end

  // Restore x when the row does not subtract.
  assign r_sub = qs ? diff : x;

endmodule

`default_nettype wire

/* div_array/div_array.sv */
`timescale 1ns/1ps
`default_nettype none

module div_array import div_pkg::*; #(
  parameter int APPROX_ROWS = APPROX_ROWS_DEFAULT
) (
  input  dividend_t n,
  input  divisor_t  d,
  output quot_t     q,
  output quot_t     r
);

  // ============================================================
  // Cell grid: row i computes quotient bit i, column j is the
  // divisor bit position within the row.
  // ============================================================
  logic [7:0] bout_l [8];
  logic [7:0] r_l    [8];

  for (genvar i = 0; i < 8; i++) begin : g_row
    localparam bit ROW_APPROX = (i < APPROX_ROWS);

    logic [7:0] x_in;
    logic [7:0] b_in;

    assign b_in = {bout_l[i][6:0], 1'b0}; // Borrow ripples upward from column 0.

    if (i == 7) begin : g_top
      assign x_in = n[14:7];                    // Top row reads the dividend directly.
      assign q[i] = n[15] | ~bout_l[i][7];
    end else begin : g_low
      assign x_in = {r_l[i+1][6:0], n[i]};      // Shifted partial remainder plus next bit.
      assign q[i] = r_l[i+1][7] | ~bout_l[i][7];
    end

    for (genvar j = 0; j < 8; j++) begin : g_col
      div_cell #(
        .APPROX (ROW_APPROX)
      ) u_cell (
        .x     (x_in[j]),
        .y     (d[j]),
        .bin   (b_in[j]),
        .qs    (q[i]),
        .r_sub (r_l[i][j]),
        .bout  (bout_l[i][j])
      );
    end
  end

  assign r = r_l[0]; // Final row holds the remainder.

endmodule

`default_nettype wire

/* src/div_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module div_datapath import div_pkg::*; #(
  parameter int APPROX_ROWS = APPROX_ROWS_DEFAULT
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_strobe,
  input  dividend_t n,
  input  divisor_t  d,
  div_sample_if.src smp,
  output quot_t     q,
  output quot_t     r
);

  dividend_t n_q;
  divisor_t  d_q;
  logic      op_vld;
  logic      res_vld;
  quot_t     q_apx_c, r_apx_c;
  quot_t     q_ref_c, r_ref_c;
  quot_t     q_apx_q, r_apx_q;
  quot_t     q_ref_q, r_ref_q;

  always_ff @(posedge clk) begin
    if (in_strobe) begin
      n_q <= n;
      d_q <= d;
    end
    if (op_vld) begin
      q_apx_q <= q_apx_c;
      r_apx_q <= r_apx_c;
      q_ref_q <= q_ref_c;
      r_ref_q <= r_ref_c;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      op_vld  <= 1'b0;
      res_vld <= 1'b0;
    end else begin
      op_vld  <= in_strobe;
      res_vld <= op_vld;
    end
  end

  div_array #(.APPROX_ROWS(APPROX_ROWS)) u_apx (.n(n_q), .d(d_q), .q(q_apx_c), .r(r_apx_c));
  div_array #(.APPROX_ROWS(0)) u_ref (.n(n_q), .d(d_q), .q(q_ref_c), .r(r_ref_c));

  assign smp.strobe = res_vld;
  assign smp.q_apx  = q_apx_q;
  assign smp.r_apx  = r_apx_q;
  assign smp.q_ref  = q_ref_q;
  assign smp.r_ref  = r_ref_q;

  assign q = q_apx_q;
  assign r = r_apx_q;

endmodule

`default_nettype wire

/* src/batch_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module batch_fsm import div_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic batch_start,
  input  logic last,
  output logic count_en,
  output logic count_clr,
  output logic acc_en,
  output logic acc_clr,
  output logic busy,
  output logic batch_done
);

  batch_state_e state_q, state_d;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (batch_start) state_d = COLLECT;
      COLLECT: if (last) state_d = REPORT;
      REPORT:  state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // Start clears both counter and accumulator in the same cycle.
  assign count_clr  = (state_q == IDLE) && batch_start;
  assign acc_clr    = count_clr;
  assign count_en   = (state_q == COLLECT);
  assign acc_en     = count_en;
  assign busy       = (state_q != IDLE);
  assign batch_done = (state_q == REPORT); // Single cycle, REPORT always exits.

endmodule

`default_nettype wire

/* src/sample_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_counter import div_pkg::*; #(
  parameter int BATCH_LEN = BATCH_LEN_DEFAULT
) (
  input  logic clk,
  input  logic rst_n,
  input  logic count_clr,
  input  logic count_en,
  input  logic strobe,
  output logic last
);

  count_t cnt_q;
  logic   take;

  assign take = count_en & strobe;

  always_ff @(posedge clk) begin
    if (!rst_n || count_clr) begin
      cnt_q <= '0;
    end else if (take) begin
      cnt_q <= cnt_q + count_t'(1);
    end
  end

  assign last = take && (cnt_q == count_t'(BATCH_LEN - 1)); // High on the final accepted strobe.

endmodule

`default_nettype wire

/* src/err_accum.sv */
`timescale 1ns/1ps
`default_nettype none

module err_accum import div_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      acc_clr,
  input  logic      acc_en,
  div_sample_if.dst smp,
  output err_sum_t  err_sum,
  output err_max_t  err_max,
  output count_t    miss_count
);

  quot_t abs_err;
  logic  add;
  logic  miss;

  // ============================================================
  // Per-sample error terms
  // ============================================================
  assign abs_err = (smp.q_apx > smp.q_ref) ? (smp.q_apx - smp.q_ref)
                                           : (smp.q_ref - smp.q_apx);
  assign miss    = (smp.q_apx != smp.q_ref) || (smp.r_apx != smp.r_ref);
  assign add     = acc_en & smp.strobe;

  // ============================================================
  // Statistics registers
  // ============================================================
  always_ff @(posedge clk) begin
    if (!rst_n || acc_clr) begin
      err_sum    <= '0;
      err_max    <= '0;
      miss_count <= '0;
    end else if (add) begin
      err_sum <= err_sum + err_sum_t'(abs_err);
      if (err_max_t'(abs_err) > err_max) begin
        err_max <= err_max_t'(abs_err);
      end
      if (miss) begin
        miss_count <= miss_count + count_t'(1); // Quotient or remainder off.
      end
    end
  end

endmodule

`default_nettype wire

/* src/approx_div_top.sv */
`timescale 1ns/1ps
`default_nettype none

module approx_div_top import div_pkg::*; #(
  parameter int APPROX_ROWS = APPROX_ROWS_DEFAULT,
  parameter int BATCH_LEN   = BATCH_LEN_DEFAULT
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_strobe,
  input  logic      batch_start,
  input  dividend_t n,
  input  divisor_t  d,
  output logic      out_strobe,
  output logic      busy,
  output logic      batch_done,
  output quot_t     q,
  output quot_t     r,
  output err_sum_t  err_sum,
  output err_max_t  err_max,
  output count_t    miss_count
);

  div_sample_if smp_if ();

  logic count_en;
  logic count_clr;
  logic acc_en;
  logic acc_clr;
  logic last;

  div_datapath #(
    .APPROX_ROWS (APPROX_ROWS)
  ) u_datapath (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_strobe (in_strobe),
    .n         (n),
    .d         (d),
    .smp       (smp_if.src),
    .q         (q),
    .r         (r)
  );

  batch_fsm u_fsm (
    .clk         (clk),
    .rst_n       (rst_n),
    .batch_start (batch_start),
    .last        (last),
    .count_en    (count_en),
    .count_clr   (count_clr),
    .acc_en      (acc_en),
    .acc_clr     (acc_clr),
    .busy        (busy),
    .batch_done  (batch_done)
  );

  // Counts result strobes so its last flag lines up with the accumulator.
  sample_counter #(
    .BATCH_LEN (BATCH_LEN)
  ) u_counter (
    .clk       (clk),
    .rst_n     (rst_n),
    .count_clr (count_clr),
    .count_en  (count_en),
    .strobe    (smp_if.strobe),
    .last      (last)
  );

  err_accum u_accum (
    .clk        (clk),
    .rst_n      (rst_n),
    .acc_clr    (acc_clr),
    .acc_en     (acc_en),
    .smp        (smp_if.dst),
    .err_sum    (err_sum),
    .err_max    (err_max),
    .miss_count (miss_count)
  );

  assign out_strobe = smp_if.strobe;

endmodule

`default_nettype wire

/* verification/approx_div_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module approx_div_asserts (
  input logic clk,
  input logic rst_n,
  input logic in_strobe,
  input logic out_strobe,
  input logic busy,
  input logic batch_done
);

  int fails; // Failed assertion count.

  initial fails = 0;

  // Operand register, then result register.
  a_strobe_latency: assert property (@(posedge clk) disable iff (!rst_n)
    in_strobe |-> ##2 out_strobe)
    else begin
      $error("out_strobe did not follow in_strobe");
      fails++;
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    batch_done |=> !batch_done)
    else begin
      $error("batch_done held longer than one cycle");
      fails++;
    end

  a_reset_idle: assert property (@(posedge clk) !rst_n |=> !busy)
    else begin
      $error("busy high right after reset");
      fails++;
    end

endmodule

`default_nettype wire

/* verification/approx_div_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module approx_div_checker import div_pkg::*; #(
  parameter int APPROX_ROWS = APPROX_ROWS_DEFAULT,
  parameter int BATCH_LEN   = BATCH_LEN_DEFAULT
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_strobe,
  input  logic      batch_start,
  input  dividend_t n,
  input  divisor_t  d,
  input  logic      out_strobe,
  input  logic      busy,
  input  logic      batch_done,
  input  quot_t     q,
  input  quot_t     r,
  input  err_sum_t  err_sum,
  input  err_max_t  err_max,
  input  count_t    miss_count,
  output int        errors,
  output int        pending
);

  localparam int LATENCY = 2; // Capture edge to result edge.

  dividend_t    n_fifo[$];
  divisor_t     d_fifo[$];
  int           t_fifo[$];
  int           cyc;
  int           cnt;
  batch_state_e st;
  err_sum_t     sum_exp;
  err_max_t     max_exp;
  count_t       miss_exp;

  // ============================================================
  // Reference model, one subtract cell at a time
  // ============================================================
  function automatic logic [15:0] approx_div_model(input dividend_t nn, input divisor_t dd,
                                                   input int rows);
    logic [7:0] x;
    logic [7:0] rem;
    logic [7:0] df;
    logic [7:0] qv;
    logic       top;
    logic       b;
    logic       y;
    rem = '0;
    qv  = '0;
    for (int i = 7; i >= 0; i--) begin
      x   = (i == 7) ? nn[14:7] : {rem[6:0], nn[i]};
      top = (i == 7) ? nn[15] : rem[7];
      b   = 1'b0;
      for (int j = 0; j < 8; j++) begin
        y = dd[j];
        if (i < rows) begin
          df[j] = !(!x[j] && y && !b);
          b     = y || b;
        end else begin
          df[j] = x[j] ^ y ^ b;
          b     = (!x[j] && y) || ((x[j] == y) && b);
        end
      end
      qv[i] = top | ~b;
      rem   = qv[i] ? df : x;
    end
    return {qv, rem};
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("Mismatch %s: got 0x%0h, expected 0x%0h at cycle %0d", sig, got, want, cyc);
    errors++;
  endtask

  always @(posedge clk) begin
    logic [15:0] apx;
    logic [15:0] ref_res;
    dividend_t   nn;
    divisor_t    dd;
    quot_t       abs_err;
    if (!rst_n) begin
      n_fifo.delete();
      d_fifo.delete();
      t_fifo.delete();
      errors   = 0;
      cyc      = 0;
      cnt      = 0;
      st       = IDLE;
      sum_exp  = '0;
      max_exp  = '0;
      miss_exp = '0;
    end else begin
      cyc++;
      if (batch_done !== (st == REPORT)) begin
        if (st == REPORT) begin
          $display("batch_done missing at cycle %0d", cyc);
          errors++;
        end else begin
          report_mismatch("batch_done", batch_done, 0);
        end
      end
      if (busy !== (st != IDLE)) report_mismatch("busy", busy, st != IDLE);
      if (err_sum !== sum_exp) report_mismatch("err_sum", err_sum, sum_exp);
      if (err_max !== max_exp) report_mismatch("err_max", err_max, max_exp);
      if (miss_count !== miss_exp) report_mismatch("miss_count", miss_count, miss_exp);

      if (in_strobe) begin
        ref_res = approx_div_model(n, d, 0);
        if (ref_res != {8'(n / d), 8'(n % d)}) begin
          report_mismatch("exact model", ref_res, {8'(n / d), 8'(n % d)});
        end
        n_fifo.push_back(n);
        d_fifo.push_back(d);
        t_fifo.push_back(cyc);
      end

      if (out_strobe && n_fifo.size() == 0) begin
        $display("unexpected out_strobe with no sample in flight at cycle %0d", cyc);
        errors++;
      end else if (out_strobe) begin
        nn = n_fifo.pop_front();
        dd = d_fifo.pop_front();
        if (cyc - t_fifo[0] != LATENCY) report_mismatch("out_strobe latency",
                                                       cyc - t_fifo[0], LATENCY);
        void'(t_fifo.pop_front());
        apx     = approx_div_model(nn, dd, APPROX_ROWS);
        ref_res = approx_div_model(nn, dd, 0);
        if (q !== apx[15:8]) report_mismatch("q", q, apx[15:8]);
        if (r !== apx[7:0]) report_mismatch("r", r, apx[7:0]);
        if (st == COLLECT) begin
          abs_err = (apx[15:8] > ref_res[15:8]) ? apx[15:8] - ref_res[15:8]
                                                : ref_res[15:8] - apx[15:8];
          sum_exp = sum_exp + err_sum_t'(abs_err);
          if (abs_err > max_exp) max_exp = abs_err;
          if (apx != ref_res) miss_exp = miss_exp + count_t'(1);
          cnt++;
        end
      end

      // Mirror of the batch controller.
      case (st)
        IDLE: if (batch_start) begin
          st       = COLLECT;
          cnt      = 0;
          sum_exp  = '0;
          max_exp  = '0;
          miss_exp = '0;
        end
        COLLECT: if (cnt == BATCH_LEN) st = REPORT;
        default: st = IDLE;
      endcase
    end
    pending = n_fifo.size();
  end

endmodule

`default_nettype wire

/* verification/approx_div_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module approx_div_tb import div_pkg::*; ();

  localparam int APPROX_ROWS = APPROX_ROWS_DEFAULT;
  localparam int BATCH_LEN   = BATCH_LEN_DEFAULT;
  localparam int N_RANDOM    = 200;
  localparam int MAX_GAP     = 3;
  // Reset, directed, random and loose samples, batches at worst-case gaps, then margin.
  localparam int TIMEOUT_CYCLES = 10 + 16 + N_RANDOM * 3 + 40 + 3 * BATCH_LEN * (MAX_GAP + 1)
                                  + 300;

  logic      clk;
  logic      rst_n;
  logic      in_strobe;
  logic      batch_start;
  dividend_t n;
  divisor_t  d;
  logic      out_strobe;
  logic      busy;
  logic      batch_done;
  quot_t     q;
  quot_t     r;
  err_sum_t  err_sum;
  err_max_t  err_max;
  count_t    miss_count;
  int        chk_errors;
  int        pending;
  int        tb_errors;
  int        assert_fails;
  int        cycles;

  approx_div_top #(.APPROX_ROWS(APPROX_ROWS), .BATCH_LEN(BATCH_LEN)) approx_div_top_i (
    .clk(clk), .rst_n(rst_n), .in_strobe(in_strobe), .batch_start(batch_start),
    .n(n), .d(d), .out_strobe(out_strobe), .busy(busy), .batch_done(batch_done),
    .q(q), .r(r), .err_sum(err_sum), .err_max(err_max), .miss_count(miss_count)
  );

  approx_div_checker #(.APPROX_ROWS(APPROX_ROWS), .BATCH_LEN(BATCH_LEN)) checker_i (
    .clk(clk), .rst_n(rst_n), .in_strobe(in_strobe), .batch_start(batch_start),
    .n(n), .d(d), .out_strobe(out_strobe), .busy(busy), .batch_done(batch_done),
    .q(q), .r(r), .err_sum(err_sum), .err_max(err_max), .miss_count(miss_count),
    .errors(chk_errors), .pending(pending)
  );

  bind approx_div_top approx_div_asserts asserts_i (
    .clk(clk), .rst_n(rst_n), .in_strobe(in_strobe), .out_strobe(out_strobe),
    .busy(busy), .batch_done(batch_done)
  );

  assign assert_fails = approx_div_top_i.asserts_i.fails;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic drive_sample(input dividend_t nn, input divisor_t dd);
    in_strobe = 1'b1;
    n         = nn;
    d         = dd;
    @(negedge clk);
  endtask

  task automatic idle(input int num);
    in_strobe = 1'b0;
    repeat (num) @(negedge clk);
  endtask

  // High dividend byte stays below the divisor.
  task automatic drive_random(input int gap);
    divisor_t   dd;
    logic [7:0] hi;
    dd = divisor_t'($urandom_range(255, 1));
    hi = 8'($urandom % dd);
    drive_sample({hi, 8'($urandom)}, dd);
    if (gap > 0) idle(gap);
  endtask

  task automatic run_batch(input int max_gap, input bit restart_mid);
    batch_start = 1'b1;
    @(negedge clk);
    for (int k = 0; k < BATCH_LEN; k++) begin
      batch_start = restart_mid && (k == BATCH_LEN / 2); // Ignored while busy.
      drive_random((k == BATCH_LEN - 1) ? 0 : $urandom_range(max_gap, 0));
    end
    batch_start = 1'b0;
    in_strobe   = 1'b0;
    while (!batch_done) @(negedge clk);
    idle(3);
  endtask

  // ============================================================
  // Stimulus
  // ============================================================
  initial begin
    void'($urandom(32'h43bb));
    tb_errors   = 0;
    rst_n       = 1'b0;
    in_strobe   = 1'b0;
    batch_start = 1'b0;
    n           = '0;
    d           = 8'h01;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    idle(2);

    drive_sample(16'h0000, 8'h01);
    drive_sample(16'h00ff, 8'h01);
    drive_sample(16'hfeff, 8'hff);
    drive_sample(16'h7fff, 8'h80);
    drive_sample(16'h7f80, 8'h80);
    drive_sample(16'h0064, 8'h07);
    drive_sample(16'h1234, 8'h13);
    drive_sample(16'h00ff, 8'hff);
    idle(3);

    for (int k = 0; k < N_RANDOM; k++) drive_random($urandom_range(2, 0));
    idle(4);

    run_batch(MAX_GAP, 1'b0);
    for (int k = 0; k < 10; k++) drive_random(1); // Outside any batch.
    idle(3);
    run_batch(0, 1'b1);
    run_batch(1, 1'b0);
    for (int k = 0; k < 8; k++) drive_random(0);
    idle(6);

    if (pending != 0) begin
      $display("%0d samples never came back on out_strobe", pending);
      tb_errors++;
    end
    $display("Error count: checker %0d, assertions %0d, testbench %0d", chk_errors,
             assert_fails, tb_errors);
    if (chk_errors == 0 && assert_fails == 0 && tb_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: stimulus still running after %0d cycles", cycles);
    $display("Error count: checker %0d, assertions %0d, testbench %0d", chk_errors,
             assert_fails, tb_errors + 1);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* approx_div_top.f */
common/div_pkg.sv
common/div_sample_if.sv
div_array/div_cell.sv
div_array/div_array.sv
src/div_datapath.sv
src/batch_fsm.sv
src/sample_counter.sv
src/err_accum.sv
src/approx_div_top.sv
verification/approx_div_asserts.sv
verification/approx_div_checker.sv
verification/approx_div_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then look for the pass line in the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 --top-module approx_div_tb \
  -f approx_div_top.f -o approx_div_sim > build.log 2>&1 \
  && ./obj_dir/approx_div_sim > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -q "^NO ERRORS$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
